// File: Bender.yml
package:
  name: frontend_mem

sources:
  - mem_pkg.sv
  - icache_mem.sv
  - icache_ctrl.sv
  - fetch_unit.sv
  - data_port.sv
  - mem_arbiter.sv
  - frontend_mem.sv
  - target: test
    files:
      - tb_clock.sv
      - tb_memory.sv
      - tb_frontend_mem.sv

// File: data_port.sv
`timescale 1ns/1ps
`default_nettype none

module data_port (
  input  wire logic              clock,
  input  wire logic              rst_n,
  input  wire logic              data_req,
  input  wire logic              data_write,
  input  wire mem_pkg::addr_t    data_addr,
  input  wire mem_pkg::word_t    data_wdata,
  input  wire mem_pkg::mem_tag_t mem_response,
  input  wire mem_pkg::mem_tag_t mem_tag,
  input  wire mem_pkg::word_t    mem_data,
  output mem_pkg::mem_cmd_t      mem_command,
  output mem_pkg::addr_t         mem_addr,
  output mem_pkg::word_t         mem_wdata,
  output logic                   data_busy,
  output logic                   load_valid,
  output mem_pkg::word_t         load_data
);
  import mem_pkg::*;

  typedef enum logic [1:0] {
    DP_IDLE,
    DP_REQ,   // Command on the bus until accepted
    DP_WAIT   // Load accepted, waiting for the tagged reply
  } dp_state_t;

  dp_state_t state;
  logic      req_write;
  addr_t     req_addr;
  word_t     req_wdata;
  mem_tag_t  ld_tag;
  logic      accept;
  logic      load_done;

  assign load_done = (state == DP_WAIT) && (mem_tag == ld_tag);
  assign data_busy = (state != DP_IDLE) && !load_done;
  assign accept    = data_req && !data_busy;  // Ignored while busy

  assign load_valid = load_done;
  assign load_data  = mem_data;

  assign mem_command = (state != DP_REQ) ? BUS_NONE :
                       (req_write ? BUS_STORE : BUS_LOAD);
  assign mem_addr    = req_addr;
  assign mem_wdata   = req_wdata;

  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
      state <= DP_IDLE;
    else if (accept)
      state <= DP_REQ;
    else
    begin
      case (state)
        DP_REQ:
          if (mem_response != '0)
            state <= req_write ? DP_IDLE : DP_WAIT;  // Store ends here
        DP_WAIT:
          if (load_done)
            state <= DP_IDLE;
        default:
          state <= DP_IDLE;
      endcase
    end
  end

  // Request and tag capture
  always_ff @(posedge clock)
  begin
    if (accept)
    begin
      req_write <= data_write;
      req_addr  <= data_addr;
      req_wdata <= data_wdata;
    end
    if ((state == DP_REQ) && (mem_response != '0))
      ld_tag <= mem_response;
  end

endmodule

`default_nettype wire

// File: fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
  input  wire logic           clock,
  input  wire logic           rst_n,
  input  wire logic           stall,
  input  wire logic           redirect,
  input  wire mem_pkg::addr_t redirect_pc,
  input  wire mem_pkg::word_t line,
  input  wire logic           line_valid,
  output mem_pkg::addr_t      fetch_addr,
  output mem_pkg::inst_t      inst,
  output mem_pkg::addr_t      npc,
  output logic                inst_valid
);
  import mem_pkg::*;

  addr_t pc;
  addr_t next_seq;
  inst_t line_inst;

  assign fetch_addr = pc;
  assign next_seq   = pc + 64'd4;

  // Two instructions per line, PC bit 2 picks the half
  assign line_inst = pc[2] ? line[63:32] : line[31:0];

  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
      pc <= '0;
    else if (redirect)
      pc <= redirect_pc;       // Mispredict target
    else if (line_valid && !stall)
      pc <= next_seq;
  end

  //////////////////////////////////////////////////
  // IF/ID register
  //////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
    begin
      inst       <= NOOP_INST;
      npc        <= '0;
      inst_valid <= 1'b0;
    end
    else if (redirect)
    begin
      inst       <= NOOP_INST;  // Flush
      npc        <= '0;
      inst_valid <= 1'b0;
    end
    else if (!stall)
    begin
      inst       <= line_inst;
      npc        <= next_seq;
      inst_valid <= line_valid; // Low while missing
    end
  end

endmodule

`default_nettype wire

// File: frontend_mem.sv
`timescale 1ns/1ps
`default_nettype none

module frontend_mem #(
  parameter int ICACHE_IDX_BITS = mem_pkg::ICACHE_IDX_BITS
) (
  input  wire logic              clock,
  input  wire logic              rst_n,
  input  wire logic              stall,
  input  wire logic              redirect,
  input  wire mem_pkg::addr_t    redirect_pc,
  input  wire logic              data_req,
  input  wire logic              data_write,
  input  wire mem_pkg::addr_t    data_addr,
  input  wire mem_pkg::word_t    data_wdata,
  input  wire mem_pkg::mem_tag_t mem2proc_response,
  input  wire mem_pkg::word_t    mem2proc_data,
  input  wire mem_pkg::mem_tag_t mem2proc_tag,
  output mem_pkg::inst_t         inst,
  output mem_pkg::addr_t         npc,
  output logic                   inst_valid,
  output logic                   data_busy,
  output logic                   load_valid,
  output mem_pkg::word_t         load_data,
  output mem_pkg::mem_cmd_t      proc2mem_command,
  output mem_pkg::addr_t         proc2mem_addr,
  output mem_pkg::word_t         proc2mem_data
);
  import mem_pkg::*;

  // Fetch to cache
  addr_t    fetch_addr;
  word_t    icache_line;
  logic     icache_line_valid;

  // Requesters to arbiter
  mem_cmd_t inst_command;
  addr_t    inst_addr;
  mem_tag_t inst_response;
  mem_cmd_t data_command;
  addr_t    dmem_addr;
  word_t    dmem_wdata;
  mem_tag_t data_response;

  fetch_unit u_fetch_unit (
    .clock       (clock),
    .rst_n       (rst_n),
    .stall       (stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .line        (icache_line),
    .line_valid  (icache_line_valid),
    .fetch_addr  (fetch_addr),
    .inst        (inst),
    .npc         (npc),
    .inst_valid  (inst_valid)
  );

  icache_ctrl #(
    .IDX_BITS (ICACHE_IDX_BITS)
  ) u_icache_ctrl (
    .clock        (clock),
    .rst_n        (rst_n),
    .fetch_addr   (fetch_addr),
    .mem_response (inst_response),
    .mem_tag      (mem2proc_tag),   // Reply goes to both sides
    .mem_data     (mem2proc_data),
    .mem_command  (inst_command),
    .mem_addr     (inst_addr),
    .line         (icache_line),
    .line_valid   (icache_line_valid)
  );

  data_port u_data_port (
    .clock        (clock),
    .rst_n        (rst_n),
    .data_req     (data_req),
    .data_write   (data_write),
    .data_addr    (data_addr),
    .data_wdata   (data_wdata),
    .mem_response (data_response),
    .mem_tag      (mem2proc_tag),
    .mem_data     (mem2proc_data),
    .mem_command  (data_command),
    .mem_addr     (dmem_addr),
    .mem_wdata    (dmem_wdata),
    .data_busy    (data_busy),
    .load_valid   (load_valid),
    .load_data    (load_data)
  );

  mem_arbiter u_mem_arbiter (
    .data_command     (data_command),
    .data_addr        (dmem_addr),
    .data_wdata       (dmem_wdata),
    .inst_command     (inst_command),
    .inst_addr        (inst_addr),
    .mem_response     (mem2proc_response),
    .proc2mem_command (proc2mem_command),
    .proc2mem_addr    (proc2mem_addr),
    .proc2mem_data    (proc2mem_data),
    .data_response    (data_response),
    .inst_response    (inst_response)
  );

endmodule

`default_nettype wire

// File: icache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl #(
  parameter  int IDX_BITS = mem_pkg::ICACHE_IDX_BITS,
  localparam int TAG_BITS = 64 - IDX_BITS - mem_pkg::LINE_OFFSET_BITS
) (
  input  wire logic              clock,
  input  wire logic              rst_n,
  input  wire mem_pkg::addr_t    fetch_addr,
  input  wire mem_pkg::mem_tag_t mem_response,
  input  wire mem_pkg::mem_tag_t mem_tag,
  input  wire mem_pkg::word_t    mem_data,
  output mem_pkg::mem_cmd_t      mem_command,
  output mem_pkg::addr_t         mem_addr,
  output mem_pkg::word_t         line,
  output logic                   line_valid
);
  import mem_pkg::*;

  logic [IDX_BITS-1:0] cur_idx;
  logic [TAG_BITS-1:0] cur_tag;
  logic [IDX_BITS-1:0] last_idx;   // Line fetched in the previous cycle
  logic [TAG_BITS-1:0] last_tag;
  logic [IDX_BITS-1:0] miss_idx;   // Line the pending load belongs to
  logic [TAG_BITS-1:0] miss_tag;
  mem_tag_t            pend_tag;   // Zero when nothing is in flight
  logic                addr_changed;
  logic                accepted;
  logic                fill;

  //////////////////////////////////////////////////
  // Address split and miss request
  //////////////////////////////////////////////////

  assign cur_idx      = fetch_addr[LINE_OFFSET_BITS +: IDX_BITS];
  assign cur_tag      = fetch_addr[63 -: TAG_BITS];
  assign addr_changed = (cur_idx != last_idx) || (cur_tag != last_tag);

  // New fetch line drops whatever was pending for the old one
  assign mem_command = (rst_n && !line_valid && ((pend_tag == '0) || addr_changed)) ?
                       BUS_LOAD : BUS_NONE;
  assign mem_addr    = {fetch_addr[63:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}};

  assign accepted = (mem_command == BUS_LOAD) && (mem_response != '0);
  assign fill     = (pend_tag != '0) && (mem_tag == pend_tag);

  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pend_tag <= '0;
      last_idx <= '0;
      last_tag <= '0;
    end
    else
    begin
      last_idx <= cur_idx;
      last_tag <= cur_tag;
      if (accepted)
        pend_tag <= mem_response;
      else if (fill || addr_changed)
        pend_tag <= '0;  // Done, or abandoned
    end
  end

  always_ff @(posedge clock)
  begin
    if (accepted)
    begin
      miss_idx <= cur_idx;
      miss_tag <= cur_tag;
    end
  end

  //////////////////////////////////////////////////
  // Cache arrays
  //////////////////////////////////////////////////

  icache_mem #(
    .IDX_BITS (IDX_BITS)
  ) u_icache_mem (
    .clock    (clock),
    .rst_n    (rst_n),
    .wr_en    (fill),
    .wr_idx   (miss_idx),
    .wr_tag   (miss_tag),
    .wr_data  (mem_data),
    .rd_idx   (cur_idx),
    .rd_tag   (cur_tag),
    .rd_data  (line),
    .rd_valid (line_valid)
  );

endmodule

`default_nettype wire

// File: icache_mem.sv
`timescale 1ns/1ps
`default_nettype none

module icache_mem #(
  parameter  int IDX_BITS = mem_pkg::ICACHE_IDX_BITS,
  localparam int TAG_BITS = 64 - IDX_BITS - mem_pkg::LINE_OFFSET_BITS
) (
  input  wire logic                clock,
  input  wire logic                rst_n,
  input  wire logic                wr_en,
  input  wire logic [IDX_BITS-1:0] wr_idx,
  input  wire logic [TAG_BITS-1:0] wr_tag,
  input  wire mem_pkg::word_t      wr_data,
  input  wire logic [IDX_BITS-1:0] rd_idx,
  input  wire logic [TAG_BITS-1:0] rd_tag,
  output mem_pkg::word_t           rd_data,
  output logic                     rd_valid
);
  import mem_pkg::*;

  localparam int LINES = 1 << IDX_BITS;

  word_t               data_q [LINES];
  logic [TAG_BITS-1:0] tag_q  [LINES];
  logic [LINES-1:0]    valid_q;

  // Line fill from the memory reply
  always_ff @(posedge clock)
  begin
    if (wr_en)
    begin
      data_q[wr_idx] <= wr_data;
      tag_q[wr_idx]  <= wr_tag;
    end
  end

  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
      valid_q <= '0;  // All lines invalid
    else if (wr_en)
      valid_q[wr_idx] <= 1'b1;
  end

  // Lookup is combinational
  assign rd_data  = data_q[rd_idx];
  assign rd_valid = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);

endmodule

`default_nettype wire

// File: mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
  input  wire mem_pkg::mem_cmd_t data_command,
  input  wire mem_pkg::addr_t    data_addr,
  input  wire mem_pkg::word_t    data_wdata,
  input  wire mem_pkg::mem_cmd_t inst_command,
  input  wire mem_pkg::addr_t    inst_addr,
  input  wire mem_pkg::mem_tag_t mem_response,
  output mem_pkg::mem_cmd_t      proc2mem_command,
  output mem_pkg::addr_t         proc2mem_addr,
  output mem_pkg::word_t         proc2mem_data,
  output mem_pkg::mem_tag_t      data_response,
  output mem_pkg::mem_tag_t      inst_response
);
  import mem_pkg::*;

  logic data_owns;

  // Data side wins whenever it has a command
  assign data_owns = (data_command != BUS_NONE);

  assign proc2mem_command = data_owns ? data_command : inst_command;
  assign proc2mem_addr    = data_owns ? data_addr : inst_addr;
  assign proc2mem_data    = data_wdata;  // Only stores carry data

  // Acceptance goes back to the owner only
  assign data_response = data_owns ? mem_response : '0;
  assign inst_response = data_owns ? '0 : mem_response;

endmodule

`default_nettype wire

// File: mem_pkg.sv
`default_nettype none

package mem_pkg;

  //////////////////////////////////////////////////
  // Memory bus
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2
  } mem_cmd_t;

  typedef logic [3:0] mem_tag_t;   // Zero means no tag

  typedef logic [63:0] addr_t;     // Byte address
  typedef logic [63:0] word_t;     // Bus word, also one cache line
  typedef logic [31:0] inst_t;

  //////////////////////////////////////////////////
  // Instruction cache geometry
  //////////////////////////////////////////////////

  // 128 lines of one word each
  localparam int ICACHE_IDX_BITS  = 7;
  localparam int LINE_OFFSET_BITS = 3;  // Byte offset in a 64-bit line

  // Alpha bis $31,$31,$31
  localparam inst_t NOOP_INST = 32'h47ff041f;

endpackage

`default_nettype wire

// File: tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter real PERIOD_NS    = 4.0,
  parameter int  RESET_CYCLES = 3
) (
  output logic clock,
  output logic rst_n
);

  initial
  begin
    clock = 1'b0;
    forever #(PERIOD_NS / 2.0) clock = ~clock;
  end

  // Release on a falling edge, away from the DUT's sampling edge
  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: tb_frontend_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_frontend_mem;
  import mem_pkg::*;

  localparam int    SEED       = 30120;
  localparam int    INST_TOTAL = 64;
  localparam int    DATA_TOTAL = 18;
  localparam int    LIMIT      = (INST_TOTAL + DATA_TOTAL) * 20 + 200;
  localparam addr_t DATA_BASE  = 64'h8000_0000;
  localparam addr_t IGNORED    = 64'h9000_0000;  // Target of the dropped request

  logic     clock;
  logic     rst_n;
  logic     stall;
  logic     redirect;
  addr_t    redirect_pc;
  logic     data_req;
  logic     data_write;
  addr_t    data_addr;
  word_t    data_wdata;
  mem_tag_t mem2proc_response;
  word_t    mem2proc_data;
  mem_tag_t mem2proc_tag;
  inst_t    inst;
  addr_t    npc;
  logic     inst_valid;
  logic     data_busy;
  logic     load_valid;
  word_t    load_data;
  mem_cmd_t proc2mem_command;
  addr_t    proc2mem_addr;
  word_t    proc2mem_data;

  int       errors;
  int       checks;
  int       inst_count;
  int       load_count;
  int       cycles;
  addr_t    exp_npc;
  logic     stall_q;
  logic     redirect_q;
  addr_t    target_q;
  logic     released;
  addr_t    st_addr;    // Last store handed to the data port
  word_t    st_data;
  word_t    model [addr_t];
  word_t    exp_q [$];

  tb_clock u_tb_clock (
    .clock (clock),
    .rst_n (rst_n)
  );

  tb_memory u_tb_memory (
    .clock      (clock),
    .rst_n      (rst_n),
    .command    (proc2mem_command),
    .addr       (proc2mem_addr),
    .wdata      (proc2mem_data),
    .response   (mem2proc_response),
    .reply_data (mem2proc_data),
    .reply_tag  (mem2proc_tag)
  );

  frontend_mem #(
    .ICACHE_IDX_BITS (ICACHE_IDX_BITS)
  ) u_frontend_mem (
    .clock             (clock),
    .rst_n             (rst_n),
    .stall             (stall),
    .redirect          (redirect),
    .redirect_pc       (redirect_pc),
    .data_req          (data_req),
    .data_write        (data_write),
    .data_addr         (data_addr),
    .data_wdata        (data_wdata),
    .mem2proc_response (mem2proc_response),
    .mem2proc_data     (mem2proc_data),
    .mem2proc_tag      (mem2proc_tag),
    .inst              (inst),
    .npc               (npc),
    .inst_valid        (inst_valid),
    .data_busy         (data_busy),
    .load_valid        (load_valid),
    .load_data         (load_data),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .proc2mem_data     (proc2mem_data)
  );

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic inst_t inst_ref(input addr_t p);
    return p[31:0] ^ p[63:32] ^ {p[17:2], p[33:18]} ^ 32'h5a5a_0000;
  endfunction

  // Unwritten data word is the line image
  function automatic word_t data_ref(input addr_t a);
    return {inst_ref(a + 64'd4), inst_ref(a)};
  endfunction

  task automatic flag(input string msg);
    errors++;
    $display("[ERROR] %0d ns: %s", $time, msg);
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (errors == errs_before)
      $display("PASS  %s", name);
    else
      $display("FAIL  %s (%0d errors)", name, errors - errs_before);
  endtask

  task automatic wait_insts(input int n);
    while (inst_count < n)
      @(posedge clock);
  endtask

  // Falling edge where the PC sits on the second half of a cached line
  task automatic wait_line_hit;
    @(negedge clock);
    while (!(inst_valid && npc[2]))
      @(negedge clock);
  endtask

  // One data request; intrude adds a write while busy that must be dropped
  task automatic access(input logic write, input addr_t a, input word_t wd,
                        input logic intrude);
    @(negedge clock);
    while (data_busy)
      @(negedge clock);
    data_req   = 1'b1;
    data_write = write;
    data_addr  = a;
    data_wdata = wd;
    if (write)
    begin
      model[a] = wd;
      st_addr  = a;
      st_data  = wd;
    end
    else
      exp_q.push_back(model.exists(a) ? model[a] : data_ref(a));
    @(negedge clock);
    if (intrude)
    begin
      data_write = 1'b1;
      data_addr  = IGNORED;
      data_wdata = ~wd;
    end
    else
      data_req = 1'b0;
    checks++;
    if (!data_busy)
      flag("data_busy not raised after an accepted request");
    if (intrude)
    begin
      @(negedge clock);
      data_req = 1'b0;
    end
    if (write && !intrude)
    begin
      @(negedge clock);
      checks++;
      if (data_busy)
        flag("store still busy one cycle after acceptance");
    end
    while (data_busy)
      @(negedge clock);
  endtask

  //////////////////////////////////////////////////
  // Checker
  //////////////////////////////////////////////////

  always @(posedge clock)
  begin
    stall_q    <= stall;     // What the DUT saw at this edge
    redirect_q <= redirect;
    target_q   <= redirect_pc;
  end

  always @(negedge clock)
  begin
    if (!rst_n)
    begin
      checks++;
      if (proc2mem_command != BUS_NONE || inst_valid || data_busy || load_valid)
        flag("outputs active during reset");
    end
    else if (!released)
    begin
      released = 1'b1;
      checks++;
      if (inst_valid || data_busy || load_valid)
        flag("outputs active right after reset");
    end
    else
    begin
      if (redirect_q)
      begin
        checks++;
        if (inst_valid)
          flag("inst_valid high in the cycle after redirect");
        exp_npc = target_q + 64'd4;
      end
      else if (inst_valid && stall_q)
      begin
        checks++;
        if (npc != exp_npc - 64'd4)
          flag($sformatf("npc %h changed under stall, held %h", npc, exp_npc - 64'd4));
      end
      else if (inst_valid)
      begin
        checks++;
        if (npc != exp_npc)
          flag($sformatf("npc %h, expected %h", npc, exp_npc));
        else if (inst != inst_ref(exp_npc - 64'd4))
          flag($sformatf("inst %h at pc %h, expected %h", inst, exp_npc - 64'd4,
                         inst_ref(exp_npc - 64'd4)));
        exp_npc = exp_npc + 64'd4;
        inst_count++;
      end

      // Only the data port stores
      if (proc2mem_command == BUS_STORE)
      begin
        checks++;
        if (proc2mem_addr != st_addr || proc2mem_data != st_data)
          flag($sformatf("store %h to %h, expected %h to %h", proc2mem_data,
                         proc2mem_addr, st_data, st_addr));
      end

      if (load_valid)
      begin
        checks++;
        if (exp_q.size() == 0)
        begin
          errors++;
          $display("load_valid seen at %0d ns with no load outstanding", $time);
        end
        else
        begin
          word_t exp;
          exp = exp_q.pop_front();
          if (load_data != exp)
            flag($sformatf("load_data %h, expected %h", load_data, exp));
          load_count++;
        end
      end
    end
  end

  // Run limit
  always @(posedge clock)
  begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT)
    begin
      $display("Timeout: run did not finish within %0d cycles", LIMIT);
      $display("Errors found");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial
  begin : stimulus
    int    e0;
    int    n;
    addr_t a;
    word_t w;
    stall       = 1'b0;
    redirect    = 1'b0;
    redirect_pc = '0;
    data_req    = 1'b0;
    data_write  = 1'b0;
    data_addr   = '0;
    data_wdata  = '0;
    errors      = 0;
    checks      = 0;
    inst_count  = 0;
    load_count  = 0;
    cycles      = 0;
    exp_npc     = 64'd4;
    released    = 1'b0;
    st_addr     = '0;
    st_data     = '0;
    void'($urandom(SEED));

    @(posedge rst_n);
    @(negedge clock);
    @(negedge clock);
    report_test("reset state", 0);

    e0 = errors;
    wait_insts(20);
    report_test("sequential fetch", e0);

    // Stall while a valid instruction sits in IF/ID
    e0 = errors;
    n  = inst_count;
    wait_line_hit();
    stall = 1'b1;
    repeat (6) @(negedge clock);
    stall = 1'b0;
    wait_insts(n + 4);
    report_test("stall", e0);

    e0 = errors;
    wait_line_hit();
    redirect    = 1'b1;
    redirect_pc = 64'h400;
    @(negedge clock);
    redirect = 1'b0;
    n = inst_count;
    wait_insts(n + 8);
    report_test("redirect", e0);

    e0 = errors;
    for (int i = 0; i < 4; i++)
    begin
      a = DATA_BASE + (addr_t'($urandom % 4096) << 3);
      access(1'b0, a, '0, 1'b0);
    end
    for (int i = 0; i < 4; i++)
    begin
      a = DATA_BASE + (addr_t'($urandom % 4096) << 3);
      w = {$urandom, $urandom};
      access(1'b1, a, w, 1'b0);
      access(1'b0, a, '0, 1'b0);
    end
    report_test("data load and store", e0);

    // Fresh fetch region so the stream misses while data runs
    e0 = errors;
    @(negedge clock);
    redirect    = 1'b1;
    redirect_pc = 64'h2000;
    @(negedge clock);
    redirect = 1'b0;
    access(1'b1, DATA_BASE + 64'h10, 64'h0123_4567_89ab_cdef, 1'b0);
    access(1'b1, DATA_BASE + 64'h18, 64'hfedc_ba98_7654_3210, 1'b0);
    access(1'b0, DATA_BASE + 64'h10, '0, 1'b0);
    access(1'b0, DATA_BASE + 64'h18, '0, 1'b1);
    access(1'b0, IGNORED, '0, 1'b0);   // Dropped write left it untouched
    access(1'b0, DATA_BASE + 64'h20, '0, 1'b0);
    n = inst_count;
    wait_insts(n + 8);
    report_test("contention", e0);

    wait_insts(INST_TOTAL);
    repeat (2) @(negedge clock);
    if (exp_q.size() != 0)
    begin
      errors++;
      $display("%0d loads never returned load_valid", exp_q.size());
    end
    $display("Checks %0d, errors %0d, instructions %0d, loads %0d",
             checks, errors, inst_count, load_count);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb_memory.sv
`timescale 1ns/1ps
`default_nettype none

module tb_memory #(
  parameter int MIN_LAT = 2,
  parameter int MAX_LAT = 8
) (
  input  wire logic              clock,
  input  wire logic              rst_n,
  input  wire mem_pkg::mem_cmd_t command,
  input  wire mem_pkg::addr_t    addr,
  input  wire mem_pkg::word_t    wdata,
  output mem_pkg::mem_tag_t      response,
  output mem_pkg::word_t         reply_data,
  output mem_pkg::mem_tag_t      reply_tag
);
  import mem_pkg::*;

  word_t    written [addr_t];   // Lines changed by stores
  mem_tag_t next_tag;
  mem_tag_t q_tag [$];          // Loads waiting for their reply
  word_t    q_data [$];
  int       q_due [$];
  int       cycle;

  // Preloaded contents, two instructions per line
  function automatic inst_t pattern_inst(input addr_t p);
    return p[31:0] ^ p[63:32] ^ {p[17:2], p[33:18]} ^ 32'h5a5a_0000;
  endfunction

  function automatic word_t read_line(input addr_t a);
    addr_t la;
    la = {a[63:3], 3'b000};
    if (written.exists(la))
      return written[la];
    return {pattern_inst(la + 64'd4), pattern_inst(la)};
  endfunction

  // Every command is taken in the cycle it shows up
  assign response = (command != BUS_NONE) ? next_tag : '0;

  always @(posedge clock or negedge rst_n)
  begin : step
    int sel;
    if (!rst_n)
    begin
      next_tag   <= 4'd1;
      reply_tag  <= '0;
      reply_data <= '0;
      cycle = 0;
      q_tag.delete();
      q_data.delete();
      q_due.delete();
    end
    else
    begin
      cycle = cycle + 1;
      sel   = -1;
      for (int i = 0; i < q_due.size(); i++)
        if (sel < 0 && q_due[i] <= cycle)
          sel = i;
      if (sel >= 0)   // One reply per cycle, others slip
      begin
        reply_tag  <= q_tag[sel];
        reply_data <= q_data[sel];
        q_tag.delete(sel);
        q_data.delete(sel);
        q_due.delete(sel);
      end
      else
        reply_tag <= '0;

      if (command == BUS_STORE)
        written[{addr[63:3], 3'b000}] = wdata;
      else if (command == BUS_LOAD)
      begin
        q_tag.push_back(next_tag);
        q_data.push_back(read_line(addr));
        q_due.push_back(cycle + MIN_LAT + ($urandom % (MAX_LAT - MIN_LAT + 1)));
      end
      if (command != BUS_NONE)
        next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;  // Tags 1..15
    end
  end

endmodule

`default_nettype wire

// File: verilog.f
mem_pkg.sv
icache_mem.sv
icache_ctrl.sv
fetch_unit.sv
data_port.sv
mem_arbiter.sv
frontend_mem.sv
tb_clock.sv
tb_memory.sv
tb_frontend_mem.sv
